//--- Makefile
VERILATOR := verilator
VFLAGS := --binary --timing -j 0
TOP := aluExecCoreTb
FILELIST := list.f
BUILDDIR := obj_dir
LOG := sim.log
PASSTEXT := PASS: all tests

.PHONY: all run lint clean

all: run

$(BUILDDIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: $(BUILDDIR)/V$(TOP)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- list.f
src/isaPkg.sv
src/ctrlPkg.sv
src/instructionPhaseDecoder.sv
src/aluGroupDecoder.sv
src/registerFile.sv
src/alu.sv
src/aluExecCore.sv
verification/aluExecChecker.sv
verification/aluExecCoreTb.sv

//--- src/alu.sv
`timescale 1ns/1ps

module alu #(
	parameter int dataWidth = 16
) (
	input  logic                             CLK,
	input  logic                             rstN,
	input  logic [dataWidth-1:0]             regaData,
	input  logic [dataWidth-1:0]             regbData,
	input  logic [isaPkg::argWidth-1:0]      argByte,
	input  logic [isaPkg::opWidth-1:0]       aluOp,
	input  logic                             aluaSrc,
	input  logic [ctrlPkg::alubSrcWidth-1:0] alubSrc,
	input  logic                             aluLd,
	input  logic                             cclLd,
	output logic [dataWidth-1:0]             resultData,
	output logic                             zero,
	output logic                             negative,
	output logic                             carry
);

	logic [dataWidth-1:0] operandA;
	logic [dataWidth-1:0] operandB;
	logic [dataWidth-1:0] resultNext;
	logic [dataWidth:0] wide;
	logic carryNext;
	logic [ctrlPkg::flagWidth-1:0] ccl;

	assign operandA = (aluaSrc == ctrlPkg::aluaSrcRegA) ? regaData : '0;

	always_comb begin
		case (alubSrc)
			ctrlPkg::alubSrcRegB: operandB = regbData;
			ctrlPkg::alubSrcArgU4: operandB = dataWidth'(argByte[3:0]);
			ctrlPkg::alubSrcArgU8: operandB = dataWidth'(argByte);
			ctrlPkg::alubSrcU8RegB: operandB = dataWidth'(regbData[8 +: 8]);
			default: operandB = '0;
		endcase
	end

	// not and shl act on A alone, mov copies B.
	always_comb begin
		wide = '0;
		resultNext = '0;
		carryNext = 1'b0;
		case (aluOp)
			isaPkg::opAnd: resultNext = operandA & operandB;
			isaPkg::opOr: resultNext = operandA | operandB;
			isaPkg::opXor: resultNext = operandA ^ operandB;
			isaPkg::opAdd: begin
				wide = {1'b0, operandA} + {1'b0, operandB};
				resultNext = wide[dataWidth-1:0];
				carryNext = wide[dataWidth]; // carry out.
			end
			isaPkg::opSub: begin
				wide = {1'b0, operandA} - {1'b0, operandB};
				resultNext = wide[dataWidth-1:0];
				carryNext = wide[dataWidth]; // borrow.
			end
			isaPkg::opMov: resultNext = operandB;
			isaPkg::opNot: resultNext = ~operandA;
			isaPkg::opShl: begin
				resultNext = {operandA[dataWidth-2:0], 1'b0};
				carryNext = operandA[dataWidth-1];
			end
			default: resultNext = operandA;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			resultData <= '0;
			ccl <= '0;
		end else begin
			if (aluLd) begin
				resultData <= resultNext;
			end
			if (cclLd) begin
				ccl[ctrlPkg::flagZero] <= (resultNext == '0);
				ccl[ctrlPkg::flagNegative] <= resultNext[dataWidth-1];
				ccl[ctrlPkg::flagCarry] <= carryNext;
			end
		end
	end

	assign zero = ccl[ctrlPkg::flagZero];
	assign negative = ccl[ctrlPkg::flagNegative];
	assign carry = ccl[ctrlPkg::flagCarry];

endmodule

//--- src/aluExecCore.sv
`timescale 1ns/1ps

module aluExecCore #(
	parameter int dataWidth = 16
) (
	input  logic                            CLK,
	input  logic                            rstN,
	input  logic [isaPkg::instrWidth-1:0]   instruction,
	output logic                            fetch,
	output logic                            regWen,
	output logic [isaPkg::regAddrWidth-1:0] regWaddr,
	output logic [dataWidth-1:0]            regWdata,
	output logic                            zero,
	output logic                            negative,
	output logic                            carry
);

	logic execute;
	logic commit;
	logic regaClkEn;
	logic regbClkEn;
	logic [isaPkg::regAddrWidth-1:0] regbAddr;
	logic [isaPkg::opWidth-1:0] aluOp;
	logic aluaSrc;
	logic [ctrlPkg::alubSrcWidth-1:0] alubSrc;
	logic [isaPkg::argWidth-1:0] argByte;
	logic aluLd;
	logic cclLd;
	logic [dataWidth-1:0] regaData;
	logic [dataWidth-1:0] regbData;

	// decode strobe is not needed by this slice.
	instructionPhaseDecoder phase_i (
		.CLK(CLK), .rstN(rstN),
		.fetch(fetch), .decode(), .execute(execute), .commit(commit)
	);

	aluGroupDecoder decoder_i (
		.CLK(CLK), .rstN(rstN), .instruction(instruction),
		.fetch(fetch), .execute(execute), .commit(commit),
		.regaClkEn(regaClkEn), .regbClkEn(regbClkEn), .regaWen(regWen),
		.regaAddr(regWaddr), .regbAddr(regbAddr),
		.aluOp(aluOp), .aluaSrc(aluaSrc), .alubSrc(alubSrc), .argByte(argByte),
		.aluLd(aluLd), .cclLd(cclLd)
	);

	registerFile #(.dataWidth(dataWidth)) regs_i (
		.CLK(CLK), .rstN(rstN),
		.regaClkEn(regaClkEn), .regbClkEn(regbClkEn), .regaWen(regWen),
		.regaAddr(regWaddr), .regbAddr(regbAddr), .writeData(regWdata),
		.regaData(regaData), .regbData(regbData)
	);

	alu #(.dataWidth(dataWidth)) alu_i (
		.CLK(CLK), .rstN(rstN),
		.regaData(regaData), .regbData(regbData), .argByte(argByte),
		.aluOp(aluOp), .aluaSrc(aluaSrc), .alubSrc(alubSrc),
		.aluLd(aluLd), .cclLd(cclLd),
		.resultData(regWdata), .zero(zero), .negative(negative), .carry(carry)
	);

endmodule

//--- src/aluGroupDecoder.sv
`timescale 1ns/1ps

module aluGroupDecoder (
	input  logic                                  CLK,
	input  logic                                  rstN,
	input  logic [isaPkg::instrWidth-1:0]         instruction,
	input  logic                                  fetch,
	input  logic                                  execute,
	input  logic                                  commit,
	output logic                                  regaClkEn,
	output logic                                  regbClkEn,
	output logic                                  regaWen,
	output logic [isaPkg::regAddrWidth-1:0]       regaAddr,
	output logic [isaPkg::regAddrWidth-1:0]       regbAddr,
	output logic [isaPkg::opWidth-1:0]            aluOp,
	output logic                                  aluaSrc,
	output logic [ctrlPkg::alubSrcWidth-1:0]      alubSrc,
	output logic [isaPkg::argWidth-1:0]           argByte,
	output logic                                  aluLd,
	output logic                                  cclLd
);

	logic [isaPkg::instrWidth-1:0] instrReg;
	logic [isaPkg::groupWidth-1:0] group;
	logic [isaPkg::opWidth-1:0] op;
	logic [isaPkg::modeWidth-1:0] mode;
	logic aluValid;
	logic usesRegB;
	logic [ctrlPkg::regaSelWidth-1:0] regaSel;

	// instruction is held from the end of fetch until the next fetch.
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			instrReg <= '0;
		end else if (fetch) begin
			instrReg <= instruction;
		end
	end

	assign group = instrReg[isaPkg::groupLsb +: isaPkg::groupWidth];
	assign op = instrReg[isaPkg::opLsb +: isaPkg::opWidth];
	assign mode = instrReg[isaPkg::modeLsb +: isaPkg::modeWidth];
	assign argByte = instrReg[isaPkg::argLsb +: isaPkg::argWidth];

	assign aluValid = (group == isaPkg::groupAluLogic) && (op < isaPkg::opNopBase);

	always_comb begin
		case (mode)
			isaPkg::modeRegReg: begin
				regaSel = ctrlPkg::regaAddrField;
				alubSrc = ctrlPkg::alubSrcRegB;
				usesRegB = 1'b1;
			end
			isaPkg::modeRegU4: begin
				regaSel = ctrlPkg::regaAddrField;
				alubSrc = ctrlPkg::alubSrcArgU4;
				usesRegB = 1'b0;
			end
			isaPkg::modeRegbU8: begin
				regaSel = ctrlPkg::regaAddrRb;
				alubSrc = ctrlPkg::alubSrcArgU8;
				usesRegB = 1'b0;
			end
			default: begin // modeRegaU8rb, b is read from r7.
				regaSel = ctrlPkg::regaAddrRa;
				alubSrc = ctrlPkg::alubSrcU8RegB;
				usesRegB = 1'b1;
			end
		endcase
	end

	always_comb begin
		case (regaSel)
			ctrlPkg::regaAddrRb: regaAddr = isaPkg::regRb;
			ctrlPkg::regaAddrRa: regaAddr = isaPkg::regRa;
			default: regaAddr = argByte[6:4];
		endcase
	end

	assign regbAddr = (mode == isaPkg::modeRegaU8rb) ? isaPkg::regRb : argByte[2:0];

	assign aluOp = op;
	assign aluaSrc = ctrlPkg::aluaSrcRegA;

	// reads and loads in execute, write-back in commit.
	assign regaClkEn = execute & aluValid;
	assign regbClkEn = execute & aluValid & usesRegB;
	assign aluLd = execute & aluValid;
	assign cclLd = execute & aluValid & (op != isaPkg::opMov); // mov keeps the flags.
	assign regaWen = commit & aluValid;

	// the write-back must follow the result load of the execute phase.
	writeOnlyInCommit: assert property (
		@(posedge CLK) disable iff (!rstN)
		regaWen |-> $past(aluLd)
	) else $error("register write strobe without a result load in the cycle before");

endmodule

//--- src/ctrlPkg.sv
package ctrlPkg;

	// operand A source.
	localparam logic aluaSrcRegA = 1'b0;

	// operand B sources.
	localparam int alubSrcWidth = 3;
	localparam logic [alubSrcWidth-1:0] alubSrcRegB = 3'd0;
	localparam logic [alubSrcWidth-1:0] alubSrcArgU4 = 3'd1;
	localparam logic [alubSrcWidth-1:0] alubSrcArgU8 = 3'd2;
	localparam logic [alubSrcWidth-1:0] alubSrcU8RegB = 3'd3; // upper byte of rb.

	// where register A's address comes from.
	localparam int regaSelWidth = 2;
	localparam logic [regaSelWidth-1:0] regaAddrField = 2'd0; // arg[6:4].
	localparam logic [regaSelWidth-1:0] regaAddrRb = 2'd1;    // r7.
	localparam logic [regaSelWidth-1:0] regaAddrRa = 2'd2;    // r6.

	// condition code latch layout.
	localparam int flagWidth = 3;
	localparam int flagZero = 0;
	localparam int flagNegative = 1;
	localparam int flagCarry = 2;

endpackage

//--- src/instructionPhaseDecoder.sv
`timescale 1ns/1ps

module instructionPhaseDecoder (
	input  logic CLK,
	input  logic rstN,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit
);

	logic [3:0] phase; // one-hot, bit 0 is fetch.

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			phase <= 4'b0001;
		end else begin
			phase <= {phase[2:0], phase[3]};
		end
	end

	assign fetch = phase[0];
	assign decode = phase[1];
	assign execute = phase[2];
	assign commit = phase[3];

	// a lost or doubled phase bit would stall or overlap instructions.
	phaseOneHot: assert property (
		@(posedge CLK) disable iff (!rstN)
		$onehot(phase)
	) else $error("phase sequencer left its one-hot rotation");

endmodule

//--- src/isaPkg.sv
package isaPkg;

	// instruction word: group | operation | mode | argument byte.
	localparam int instrWidth = 16;
	localparam int groupWidth = 2;
	localparam int opWidth = 4;
	localparam int modeWidth = 2;
	localparam int argWidth = 8;

	localparam int groupLsb = 14;
	localparam int opLsb = 10;
	localparam int modeLsb = 8;
	localparam int argLsb = 0;

	localparam logic [groupWidth-1:0] groupAluLogic = 2'b01;

	localparam logic [opWidth-1:0] opAnd = 4'd0;
	localparam logic [opWidth-1:0] opOr = 4'd1;
	localparam logic [opWidth-1:0] opXor = 4'd2;
	localparam logic [opWidth-1:0] opAdd = 4'd3;
	localparam logic [opWidth-1:0] opSub = 4'd4;
	localparam logic [opWidth-1:0] opMov = 4'd5;
	localparam logic [opWidth-1:0] opNot = 4'd6;
	localparam logic [opWidth-1:0] opShl = 4'd7;
	localparam logic [opWidth-1:0] opNopBase = 4'd8; // 8 to 15 do nothing.

	localparam logic [modeWidth-1:0] modeRegReg = 2'd0;
	localparam logic [modeWidth-1:0] modeRegU4 = 2'd1;
	localparam logic [modeWidth-1:0] modeRegbU8 = 2'd2;
	localparam logic [modeWidth-1:0] modeRegaU8rb = 2'd3;

	localparam int regAddrWidth = 3;

	// fixed registers used by the byte modes.
	localparam logic [regAddrWidth-1:0] regRb = 3'd7;
	localparam logic [regAddrWidth-1:0] regRa = 3'd6;

endpackage

//--- src/registerFile.sv
`timescale 1ns/1ps

module registerFile #(
	parameter int dataWidth = 16
) (
	input  logic                            CLK,
	input  logic                            rstN,
	input  logic                            regaClkEn,
	input  logic                            regbClkEn,
	input  logic                            regaWen,
	input  logic [isaPkg::regAddrWidth-1:0] regaAddr,
	input  logic [isaPkg::regAddrWidth-1:0] regbAddr,
	input  logic [dataWidth-1:0]            writeData,
	output logic [dataWidth-1:0]            regaData,
	output logic [dataWidth-1:0]            regbData
);

	localparam int numRegs = 2 ** isaPkg::regAddrWidth;

	logic [dataWidth-1:0] regs [numRegs];
	logic [dataWidth-1:0] regaHold;
	logic [dataWidth-1:0] regbHold;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
			regaHold <= '0;
			regbHold <= '0;
		end else begin
			if (regaWen) begin
				regs[regaAddr] <= writeData; // write port shares the A address.
			end
			if (regaClkEn) begin
				regaHold <= regs[regaAddr];
			end
			if (regbClkEn) begin
				regbHold <= regs[regbAddr];
			end
		end
	end

	// read ports pass through while enabled and hold the last value after.
	assign regaData = regaClkEn ? regs[regaAddr] : regaHold;
	assign regbData = regbClkEn ? regs[regbAddr] : regbHold;

	knownWriteData: assert property (
		@(posedge CLK) disable iff (!rstN)
		regaWen |-> !$isunknown(writeData)
	) else $error("register write with unknown data");

endmodule

//--- verification/aluExecChecker.sv
`timescale 1ns/1ps

module aluExecChecker #(
	parameter int dataWidth = 16
) (
	input  logic                            CLK,
	input  logic                            rstN,
	input  logic [isaPkg::instrWidth-1:0]   instruction,
	input  logic                            fetch,
	input  logic                            regWen,
	input  logic [isaPkg::regAddrWidth-1:0] regWaddr,
	input  logic [dataWidth-1:0]            regWdata,
	input  logic                            zero,
	input  logic                            negative,
	input  logic                            carry,
	output int                              valueErrors,
	output int                              strobeErrors,
	output int                              commitCount
);

	logic [dataWidth-1:0] model [8]; // expected register contents.
	logic [2:0] flags;               // {carry, negative, zero}.
	logic [isaPkg::instrWidth-1:0] held;
	int cyc;                         // cycles since reset, fetch when cyc % 4 is 0.

	task automatic checkValue(input string name, input logic [dataWidth-1:0] expected,
			input logic [dataWidth-1:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, got %h at %0t", name, expected, actual, $time);
			valueErrors++;
		end
	endtask

	// carry in the top bit, result below it.
	function automatic logic [dataWidth:0] applyOp(input logic [3:0] op,
			input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		logic [dataWidth:0] out;
		case (op)
			isaPkg::opAnd: out = {1'b0, a & b};
			isaPkg::opOr: out = {1'b0, a | b};
			isaPkg::opXor: out = {1'b0, a ^ b};
			isaPkg::opAdd: out = (dataWidth+1)'(a) + (dataWidth+1)'(b);
			isaPkg::opSub: out = {a < b, a - b}; // borrow when b exceeds a.
			isaPkg::opMov: out = {1'b0, b};
			isaPkg::opNot: out = {1'b0, ~a};
			isaPkg::opShl: out = {a, 1'b0};
			default: out = '0;
		endcase
		return out;
	endfunction

	always @(posedge CLK) begin
		logic [3:0] op;
		logic [1:0] mode;
		logic [7:0] arg;
		logic [2:0] dst;
		logic [dataWidth-1:0] opA;
		logic [dataWidth-1:0] opB;
		logic [dataWidth:0] outcome;
		logic expectWrite;
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				model[i] = '0;
			end
			flags = '0;
			held = '0;
			cyc = 0;
			valueErrors = 0;
			strobeErrors = 0;
			commitCount = 0;
		end else begin
			op = held[13:10];
			mode = held[9:8];
			arg = held[7:0];
			expectWrite = (held[15:14] == isaPkg::groupAluLogic) && !op[3] && (cyc % 4 == 3);
			checkValue("fetch", dataWidth'(cyc % 4 == 0), dataWidth'(fetch));
			if (regWen !== expectWrite) begin
				if (expectWrite) begin
					$display("missing register write strobe in commit cycle %0d", cyc);
				end else begin
					$display("unexpected register write strobe in cycle %0d", cyc);
				end
				strobeErrors++;
			end
			if (expectWrite) begin
				case (mode)
					isaPkg::modeRegReg: begin
						dst = arg[6:4];
						opB = model[arg[2:0]];
					end
					isaPkg::modeRegU4: begin
						dst = arg[6:4];
						opB = dataWidth'(arg[3:0]);
					end
					isaPkg::modeRegbU8: begin
						dst = 3'd7;
						opB = dataWidth'(arg);
					end
					default: begin
						dst = 3'd6;
						opB = dataWidth'(model[7][15:8]);
					end
				endcase
				opA = model[dst];
				outcome = applyOp(op, opA, opB);
				checkValue("regWaddr", dataWidth'(dst), dataWidth'(regWaddr));
				checkValue("regWdata", outcome[dataWidth-1:0], regWdata);
				model[dst] = outcome[dataWidth-1:0];
				if (op != isaPkg::opMov) begin
					flags = {outcome[dataWidth], outcome[dataWidth-1], outcome[dataWidth-1:0] == '0};
				end
			end
			if (cyc % 4 == 3) begin
				commitCount++;
			end
			checkValue("zero", dataWidth'(flags[0]), dataWidth'(zero));
			checkValue("negative", dataWidth'(flags[1]), dataWidth'(negative));
			checkValue("carry", dataWidth'(flags[2]), dataWidth'(carry));
			if (cyc % 4 == 0) begin
				held = instruction;
			end
			cyc++;
		end
	end

endmodule

//--- verification/aluExecCoreTb.sv
`timescale 1ns/1ps

module aluExecCoreTb;

	localparam int dataWidth = 16;
	localparam int numInstr = 200;
	localparam int maxCycles = 4 * numInstr + 200; // four cycles each, plus reset and drain.

	logic CLK = 1'b0;
	logic rstN;
	logic [isaPkg::instrWidth-1:0] instruction;
	logic fetch;
	logic regWen;
	logic [isaPkg::regAddrWidth-1:0] regWaddr;
	logic [dataWidth-1:0] regWdata;
	logic zero;
	logic negative;
	logic carry;
	int valueErrors;
	int strobeErrors;
	int commitCount;
	int cycles = 0;
	int sent = 0;

	aluExecCore #(.dataWidth(dataWidth)) dut_i (
		.CLK(CLK), .rstN(rstN), .instruction(instruction), .fetch(fetch),
		.regWen(regWen), .regWaddr(regWaddr), .regWdata(regWdata),
		.zero(zero), .negative(negative), .carry(carry)
	);

	aluExecChecker #(.dataWidth(dataWidth)) checker_i (
		.CLK(CLK), .rstN(rstN), .instruction(instruction), .fetch(fetch),
		.regWen(regWen), .regWaddr(regWaddr), .regWdata(regWdata),
		.zero(zero), .negative(negative), .carry(carry),
		.valueErrors(valueErrors), .strobeErrors(strobeErrors), .commitCount(commitCount)
	);

	always #10 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= maxCycles) begin
			$display("timeout: run still going after %0d cycles", maxCycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// mostly arithmetic/logic group with a valid op, the rest exercises no-ops.
	function automatic logic [isaPkg::instrWidth-1:0] randomInstruction();
		logic [1:0] group;
		logic [3:0] op;
		group = ($urandom % 8 < 6) ? isaPkg::groupAluLogic : 2'($urandom);
		op = ($urandom % 8 < 7) ? 4'($urandom % 8) : 4'($urandom);
		return {group, op, 2'($urandom), 8'($urandom)};
	endfunction

	initial begin
		void'($urandom(32'h11e33e97));
		rstN = 1'b0;
		instruction = '0;
		repeat (2) @(posedge CLK);
		#1;
		rstN = 1'b1;
		while (sent < numInstr) begin
			if (fetch) begin
				instruction = randomInstruction();
				sent++;
			end
			@(posedge CLK);
			#1;
		end
		repeat (4) @(posedge CLK); // last instruction reaches commit.
		#1;
		$display("errors: %0d value, %0d strobe; %0d commit cycles checked",
			valueErrors, strobeErrors, commitCount);
		if (valueErrors == 0 && strobeErrors == 0 && commitCount >= numInstr) begin
			$display("PASS: all tests");
		end else begin
			if (commitCount < numInstr) begin
				$display("only %0d of %0d instructions reached commit", commitCount, numInstr);
			end
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
